// ==== bench/axi_rd_master_tb.sv ====
// AXI read master testbench
`timescale 1ns/1ps

module axi_rd_master_tb;

  import axi_rd_pkg::*;

  localparam int TIMEOUT_CYC = 500;

  // Command, slave behavior, user duty and expected status
  typedef struct packed {
    rd_cmd_t    cmd;
    logic [7:0] stall;
    logic [7:0] err_beat;  // 8'hff for none
    logic       wrong_id;
    logic       no_resp;
    logic [7:0] duty;      // rddata_rdy percent
    rd_sts_t    exp_sts;
  } row_t;

  logic              aclk = 1'b0;
  logic              aresetn;
  logic              cmd_en;
  rd_cmd_t           cmd;
  logic              cmd_ack;
  ar_chan_t          ar;
  logic              arvalid;
  logic              arready;
  r_beat_t           r;
  logic              rvalid;
  logic              rready;
  logic [DATA_W-1:0] rddata;
  logic              rddata_last;
  logic              rddata_vld;
  logic              rddata_rdy;
  rd_sts_t           rd_sts;
  logic              rd_sts_vld;
  logic              wdog_mask;
  logic [7:0]        stall_cycles;
  logic [7:0]        err_beat;
  logic              wrong_id;
  logic              no_resp;

  row_t              rows[$];
  int                err_cnt = 0;
  int                fail_cnt = 0;
  logic [31:0]       rng_state = 32'd13951;
  logic [ID_W-1:0]   exp_id = '0;  // Rolling ID expected on AR
  logic [7:0]        duty = 8'd100;

  always #10 aclk = ~aclk;

  axi_rd_master #(
    .WDOG_W    (6),
    .BUF_DEPTH (4)
  ) axi_rd_master_inst (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .cmd_en      (cmd_en),
    .cmd         (cmd),
    .cmd_ack     (cmd_ack),
    .ar          (ar),
    .arvalid     (arvalid),
    .arready     (arready),
    .r           (r),
    .rvalid      (rvalid),
    .rready      (rready),
    .rddata      (rddata),
    .rddata_last (rddata_last),
    .rddata_vld  (rddata_vld),
    .rddata_rdy  (rddata_rdy),
    .rd_sts      (rd_sts),
    .rd_sts_vld  (rd_sts_vld),
    .wdog_mask   (wdog_mask)
  );

  axi_rd_slave_model slave_inst (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .ar           (ar),
    .arvalid      (arvalid),
    .arready      (arready),
    .r            (r),
    .rvalid       (rvalid),
    .rready       (rready),
    .stall_cycles (stall_cycles),
    .err_beat     (err_beat),
    .wrong_id     (wrong_id),
    .no_resp      (no_resp)
  );

  // xorshift32
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic add_row(input logic wrap, input logic [7:0] blen, input logic [31:0] addr,
                         input logic [7:0] stall, input logic [7:0] err_b,
                         input logic bad_id, input logic silent, input logic [7:0] rdy_pct,
                         input logic [7:0] exp_cnt, input logic [2:0] exp_flags);
    row_t row;
    row.cmd.wrap = wrap;
    row.cmd.blen = blen;
    row.cmd.addr = addr;
    row.cmd.size = 3'd2;
    row.stall    = stall;
    row.err_beat = err_b;
    row.wrong_id = bad_id;
    row.no_resp  = silent;
    row.duty     = rdy_pct;
    row.exp_sts  = {exp_cnt, exp_flags};  // Flags are timeout, id_err and resp_err
    rows.push_back(row);
  endtask

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("[ERROR] %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    err_cnt++;
  endtask

  //**************************************************************************
  // One table row from command to status
  //**************************************************************************

  task automatic run_row(input int idx, input row_t row);
    logic [ADDR_W-1:0] base;
    logic [DATA_W-1:0] exp_data;
    int                cyc;
    int                beats;
    int                ar_cnt;
    logic              acked;
    logic              done;
    base   = {row.cmd.addr[ADDR_W-1:2], 2'b00};  // word aligned
    beats  = 0;
    ar_cnt = 0;
    acked  = 1'b0;
    done   = 1'b0;
    @(posedge aclk);
    stall_cycles <= row.stall;
    err_beat     <= row.err_beat;
    wrong_id     <= row.wrong_id;
    no_resp      <= row.no_resp;
    cmd          <= row.cmd;
    cmd_en       <= 1'b1;
    duty = row.duty;
    cyc = 0;
    while (!done && cyc < TIMEOUT_CYC) begin
      @(posedge aclk);
      cyc++;
      if (cmd_ack) begin
        cmd_en <= 1'b0;
        if (acked || cyc != 2) begin
          $display("Row %0d: cmd_ack repeated or not one cycle after cmd_en", idx);
          fail_cnt++;
        end
        if (!arvalid) begin
          $display("Row %0d: arvalid did not rise together with cmd_ack", idx);
          fail_cnt++;
        end
        acked = 1'b1;
      end
      if (arvalid && arready) begin
        ar_cnt++;
        if (ar.id != exp_id) report_value("ar.id", ar.id, exp_id);
        if (ar.addr != base) report_value("ar.addr", ar.addr, base);
        if (ar.len != row.cmd.blen) report_value("ar.len", ar.len, row.cmd.blen);
        if (ar.size != row.cmd.size) report_value("ar.size", ar.size, row.cmd.size);
        if (ar.burst != (row.cmd.wrap ? BURST_WRAP : BURST_INCR))
          report_value("ar.burst", ar.burst, row.cmd.wrap ? BURST_WRAP : BURST_INCR);
      end
      if (rddata_vld && rddata_rdy) begin
        exp_data = base + beats;
        if (rddata != exp_data) report_value("rddata", rddata, exp_data);
        if (rddata_last != (beats == row.cmd.blen))
          report_value("rddata_last", rddata_last, beats == row.cmd.blen);
        beats++;
      end
      if (rd_sts_vld) begin
        done = 1'b1;
        if (rd_sts != row.exp_sts) report_value("rd_sts", rd_sts, row.exp_sts);
        if (!row.exp_sts.timeout && !(rddata_vld && rddata_rdy && rddata_last)) begin
          $display("Row %0d: rd_sts_vld came without the last user beat", idx);
          fail_cnt++;
        end
      end
      rddata_rdy <= (next_rand() % 100) < duty;
    end
    cmd_en <= 1'b0;
    if (!acked) begin
      $display("Row %0d: the command never got cmd_ack", idx);
      fail_cnt++;
    end
    if (!done) begin
      $display("Row %0d: timed out waiting for rd_sts_vld", idx);
      fail_cnt++;
    end else begin
      if (ar_cnt != 1) report_value("AR transfer count", ar_cnt, 1);
      if (beats != row.exp_sts.beat_cnt) report_value("user beats", beats, row.exp_sts.beat_cnt);
    end
    exp_id = exp_id + 1'b1;
  endtask

  initial begin
    aresetn      = 1'b0;
    cmd_en       = 1'b0;
    cmd          = '0;
    rddata_rdy   = 1'b0;
    wdog_mask    = 1'b0;
    stall_cycles = '0;
    err_beat     = 8'hff;
    wrong_id     = 1'b0;
    no_resp      = 1'b0;
    //       wrap  blen   addr          stall  err    id    silent duty    cnt    flags
    add_row(1'b0, 8'd3,  32'h0000_1003, 8'd0, 8'hff, 1'b0, 1'b0, 8'd100, 8'd4,  3'b000);
    add_row(1'b1, 8'd3,  32'h0000_2010, 8'd2, 8'hff, 1'b0, 1'b0, 8'd100, 8'd4,  3'b000);
    add_row(1'b0, 8'd7,  32'h0000_3001, 8'd1, 8'hff, 1'b0, 1'b0, 8'd30,  8'd8,  3'b000);
    add_row(1'b0, 8'd5,  32'h0000_4000, 8'd0, 8'd2,  1'b0, 1'b0, 8'd60,  8'd6,  3'b001);
    add_row(1'b1, 8'd1,  32'h0000_5008, 8'd0, 8'hff, 1'b1, 1'b0, 8'd80,  8'd2,  3'b010);
    add_row(1'b0, 8'd3,  32'h0000_6000, 8'd0, 8'hff, 1'b0, 1'b1, 8'd100, 8'd0,  3'b100);
    add_row(1'b0, 8'd15, 32'h0000_7002, 8'd3, 8'hff, 1'b0, 1'b0, 8'd30,  8'd16, 3'b000);
    add_row(1'b0, 8'd0,  32'h0000_8004, 8'd0, 8'hff, 1'b0, 1'b0, 8'd100, 8'd1,  3'b000);
    repeat (2) @(posedge aclk);
    if (cmd_ack || arvalid || rready || rddata_vld || rd_sts_vld) begin
      $display("Handshake outputs are not low during reset");
      fail_cnt++;
    end
    aresetn <= 1'b1;
    foreach (rows[i])
      run_row(i, rows[i]);
    repeat (4) @(posedge aclk);
    $display("Errors: %0d value mismatches, %0d other failures", err_cnt, fail_cnt);
    if (err_cnt == 0 && fail_cnt == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== bench/axi_rd_slave_model.sv ====
// Behavioral AXI read slave
`timescale 1ns/1ps

module axi_rd_slave_model (
  input  logic                 aclk,
  input  logic                 aresetn,
  // AR channel
  input  axi_rd_pkg::ar_chan_t ar,
  input  logic                 arvalid,
  output logic                 arready,
  // R channel
  output axi_rd_pkg::r_beat_t  r,
  output logic                 rvalid,
  input  logic                 rready,
  // Response of the next burst
  input  logic [7:0]           stall_cycles,
  input  logic [7:0]           err_beat,     // 8'hff for none
  input  logic                 wrong_id,
  input  logic                 no_resp
);

  import axi_rd_pkg::*;

  ar_chan_t         req_q;     // accepted burst
  logic             busy;
  logic [7:0]       wait_cnt;
  logic [LEN_W-1:0] beat_idx;

  // Data is the burst address plus the beat index
  function automatic r_beat_t make_beat(input logic [LEN_W-1:0] idx);
    r_beat_t b;
    b.data = req_q.addr + idx;
    b.id   = wrong_id ? req_q.id ^ 1'b1 : req_q.id;
    b.resp = (idx == err_beat) ? 2'b10 : 2'b00;  // SLVERR
    b.last = (idx == req_q.len);
    return b;
  endfunction

  always @(posedge aclk) begin
    if (!aresetn) begin
      arready  <= 1'b0;
      rvalid   <= 1'b0;
      r        <= '0;
      busy     <= 1'b0;
      wait_cnt <= '0;
      beat_idx <= '0;
    end else if (!busy) begin
      arready <= 1'b1;
      if (arvalid && arready) begin
        arready  <= 1'b0;
        req_q    <= ar;
        wait_cnt <= stall_cycles;
        beat_idx <= '0;
        busy     <= !no_resp;  // silent slave drops the burst
      end
    end else if (rvalid) begin
      if (rready) begin
        if (r.last) begin
          rvalid <= 1'b0;
          busy   <= 1'b0;
        end else begin
          r        <= make_beat(beat_idx + 1'b1);
          beat_idx <= beat_idx + 1'b1;
        end
      end
    end else if (wait_cnt != '0) begin
      wait_cnt <= wait_cnt - 1'b1;  // Stall before the first beat
    end else begin
      r      <= make_beat(beat_idx);
      rvalid <= 1'b1;
    end
  end

endmodule

// ==== hw/axi_rd_master.sv ====
// AXI4 burst read master
`timescale 1ns/1ps

module axi_rd_master #(
  parameter int WDOG_W    = 9,
  parameter int BUF_DEPTH = 4
) (
  input  logic                          aclk,
  input  logic                          aresetn,
  // User command port
  input  logic                          cmd_en,
  input  axi_rd_pkg::rd_cmd_t           cmd,
  output logic                          cmd_ack,
  // AR channel
  output axi_rd_pkg::ar_chan_t          ar,
  output logic                          arvalid,
  input  logic                          arready,
  // R channel
  input  axi_rd_pkg::r_beat_t           r,
  input  logic                          rvalid,
  output logic                          rready,
  // User read data and status
  output logic [axi_rd_pkg::DATA_W-1:0] rddata,
  output logic                          rddata_last,
  output logic                          rddata_vld,
  input  logic                          rddata_rdy,
  output axi_rd_pkg::rd_sts_t           rd_sts,
  output logic                          rd_sts_vld,
  input  logic                          wdog_mask
);

  import axi_rd_pkg::*;

  //**************************************************************************
  // Internal links
  //**************************************************************************

  logic        burst_start;
  burst_info_t burst;
  logic        burst_done;
  logic        flush;
  r_beat_t     beat;
  logic        beat_valid;
  logic        beat_ready;

  rd_cmd_issuer rd_cmd_issuer_inst (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .cmd_en      (cmd_en),
    .cmd         (cmd),
    .cmd_ack     (cmd_ack),
    .ar          (ar),
    .arvalid     (arvalid),
    .arready     (arready),
    .burst_start (burst_start),
    .burst       (burst),
    .burst_done  (burst_done)
  );

  // Lets the slave run ahead of a slow user
  rd_beat_buffer #(
    .BUF_DEPTH (BUF_DEPTH)
  ) rd_beat_buffer_inst (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .flush      (flush),
    .r          (r),
    .rvalid     (rvalid),
    .rready     (rready),
    .beat       (beat),
    .beat_valid (beat_valid),
    .beat_ready (beat_ready)
  );

  rd_burst_tracker #(
    .WDOG_W (WDOG_W)
  ) rd_burst_tracker_inst (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .burst_start (burst_start),
    .burst       (burst),
    .burst_done  (burst_done),
    .beat        (beat),
    .beat_valid  (beat_valid),
    .beat_ready  (beat_ready),
    .flush       (flush),
    .rddata      (rddata),
    .rddata_last (rddata_last),
    .rddata_vld  (rddata_vld),
    .rddata_rdy  (rddata_rdy),
    .rd_sts      (rd_sts),
    .rd_sts_vld  (rd_sts_vld),
    .wdog_mask   (wdog_mask)
  );

endmodule

// ==== hw/axi_rd_pkg.sv ====
// AXI read master shared types

package axi_rd_pkg;

  //**************************************************************************
  // AXI field widths
  //**************************************************************************

  localparam int ADDR_W  = 32;
  localparam int ID_W    = 4;
  localparam int DATA_W  = 32;
  localparam int LEN_W   = 8;  // AxLEN, beats minus one
  localparam int SIZE_W  = 3;
  localparam int BURST_W = 2;
  localparam int RESP_W  = 2;

  // Burst type codes
  localparam logic [BURST_W-1:0] BURST_INCR = 2'b01;
  localparam logic [BURST_W-1:0] BURST_WRAP = 2'b10;

  // SLVERR and DECERR both have this bit set
  localparam int RESP_ERR_BIT = 1;

  //**************************************************************************
  // Channel and status payloads
  //**************************************************************************

  // User read command
  typedef struct packed {
    logic              wrap;  // 1 selects a WRAP burst
    logic [LEN_W-1:0]  blen;  // burst length is blen+1
    logic [ADDR_W-1:0] addr;
    logic [SIZE_W-1:0] size;
  } rd_cmd_t;

  // Read address channel
  typedef struct packed {
    logic [ID_W-1:0]    id;
    logic [ADDR_W-1:0]  addr;
    logic [LEN_W-1:0]   len;
    logic [SIZE_W-1:0]  size;
    logic [BURST_W-1:0] burst;
  } ar_chan_t;

  // Read data channel, one beat
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [ID_W-1:0]   id;
    logic [RESP_W-1:0] resp;
    logic              last;
  } r_beat_t;

  // What the tracker expects for the open burst
  typedef struct packed {
    logic [ID_W-1:0]  id;
    logic [LEN_W-1:0] len;
  } burst_info_t;

  // Per-burst status
  typedef struct packed {
    logic [LEN_W-1:0] beat_cnt;  // beats taken by the user
    logic             timeout;
    logic             id_err;
    logic             resp_err;
  } rd_sts_t;

endpackage

// ==== hw/rd_beat_buffer.sv ====
// Read beat buffer
`timescale 1ns/1ps

module rd_beat_buffer #(
  parameter int BUF_DEPTH = 4  // power of two
) (
  input  logic                aclk,
  input  logic                aresetn,
  input  logic                flush,
  // R channel
  input  axi_rd_pkg::r_beat_t r,
  input  logic                rvalid,
  output logic                rready,
  // To burst tracker
  output axi_rd_pkg::r_beat_t beat,
  output logic                beat_valid,
  input  logic                beat_ready
);

  import axi_rd_pkg::*;

  localparam int PTR_W = $clog2(BUF_DEPTH);

  r_beat_t          mem [BUF_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;      // entries held in mem
  logic [PTR_W:0]   count_nxt;
  logic             push;
  logic             out_load;   // output register free this cycle
  logic             mem_empty;
  logic             mem_wr;
  logic             mem_rd;

  assign push      = rvalid & rready;
  assign out_load  = ~beat_valid | beat_ready;
  assign mem_empty = (count == '0);
  assign mem_rd    = out_load & ~mem_empty;
  assign mem_wr    = push & ~(out_load & mem_empty);  // else bypass to output

  always_comb begin
    count_nxt = count;
    if (flush)
      count_nxt = '0;
    else if (mem_wr & ~mem_rd)
      count_nxt = count + 1'b1;
    else if (mem_rd & ~mem_wr)
      count_nxt = count - 1'b1;
  end

  // Pointers, fill level and space flag
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      rready <= 1'b0;
    end else begin
      count  <= count_nxt;
      rready <= (count_nxt != (PTR_W + 1)'(BUF_DEPTH));
      if (flush) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
      end else begin
        if (mem_wr) wr_ptr <= wr_ptr + 1'b1;
        if (mem_rd) rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (mem_wr)
      mem[wr_ptr] <= r;
  end

  // Registered output, oldest entry first
  always_ff @(posedge aclk) begin
    if (!aresetn)
      beat_valid <= 1'b0;
    else if (flush)
      beat_valid <= 1'b0;
    else if (out_load)
      beat_valid <= ~mem_empty | push;
  end

  always_ff @(posedge aclk) begin
    if (mem_rd)
      beat <= mem[rd_ptr];
    else if (out_load & push)
      beat <= r;
  end

endmodule

// ==== hw/rd_burst_tracker.sv ====
// Read burst tracker
`timescale 1ns/1ps

module rd_burst_tracker #(
  parameter int WDOG_W = 9  // timeout when the top bit sets
) (
  input  logic                            aclk,
  input  logic                            aresetn,
  // From and to the issuer
  input  logic                            burst_start,
  input  axi_rd_pkg::burst_info_t         burst,
  output logic                            burst_done,
  // Beat buffer side
  input  axi_rd_pkg::r_beat_t             beat,
  input  logic                            beat_valid,
  output logic                            beat_ready,
  output logic                            flush,
  // User read data
  output logic [axi_rd_pkg::DATA_W-1:0]   rddata,
  output logic                            rddata_last,
  output logic                            rddata_vld,
  input  logic                            rddata_rdy,
  output axi_rd_pkg::rd_sts_t             rd_sts,
  output logic                            rd_sts_vld,
  input  logic                            wdog_mask
);

  import axi_rd_pkg::*;

  burst_info_t       exp_q;       // expected ID and length
  logic              open_q;      // burst in progress
  logic              last_in_q;   // final beat already taken from buffer
  logic              to_q;        // timeout pulse
  logic              id_err_q;
  logic              resp_err_q;
  logic [LEN_W-1:0]  load_cnt;    // beats taken from the buffer
  logic [LEN_W-1:0]  acc_cnt;     // beats taken by the user
  logic [WDOG_W-1:0] wdog_q;
  logic              buf_xfer;
  logic              usr_xfer;
  logic              usr_last;
  logic              beat_last;
  logic              wdog_exp;

  // No beats past the final one of this burst
  assign beat_ready = open_q & ~last_in_q & (~rddata_vld | rddata_rdy);
  assign buf_xfer   = beat_valid & beat_ready;
  assign usr_xfer   = rddata_vld & rddata_rdy;
  assign usr_last   = usr_xfer & rddata_last;

  // Last flag or beat number len+1, whichever comes first
  assign beat_last = beat.last | (load_cnt == exp_q.len);

  // Any transfer this cycle keeps the burst alive
  assign wdog_exp = open_q & wdog_q[WDOG_W-1] & ~wdog_mask & ~buf_xfer & ~usr_xfer;

  //**************************************************************************
  // Burst state
  //**************************************************************************

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      open_q    <= 1'b0;
      last_in_q <= 1'b0;
      to_q      <= 1'b0;
    end else begin
      to_q <= wdog_exp;
      if (burst_start) begin
        open_q    <= 1'b1;
        last_in_q <= 1'b0;
      end else begin
        if (usr_last | wdog_exp)
          open_q <= 1'b0;
        if (buf_xfer & beat_last)
          last_in_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (burst_start)
      exp_q <= burst;
  end

  // Beat counters and error flags, cleared per burst
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      load_cnt   <= '0;
      acc_cnt    <= '0;
      id_err_q   <= 1'b0;
      resp_err_q <= 1'b0;
    end else if (burst_start) begin
      load_cnt   <= '0;
      acc_cnt    <= '0;
      id_err_q   <= 1'b0;
      resp_err_q <= 1'b0;
    end else begin
      if (buf_xfer) begin
        load_cnt <= load_cnt + 1'b1;
        if (beat.id != exp_q.id)     id_err_q   <= 1'b1;
        if (beat.resp[RESP_ERR_BIT]) resp_err_q <= 1'b1;
      end
      if (usr_xfer)
        acc_cnt <= acc_cnt + 1'b1;
    end
  end

  //**************************************************************************
  // Watchdog
  //**************************************************************************

  always_ff @(posedge aclk) begin
    if (!aresetn)
      wdog_q <= '0;
    else if (burst_start | buf_xfer | usr_xfer)
      wdog_q <= '0;
    else if (open_q & ~wdog_mask & ~wdog_q[WDOG_W-1])  // holds once expired
      wdog_q <= wdog_q + 1'b1;
  end

  //**************************************************************************
  // User data and status
  //**************************************************************************

  always_ff @(posedge aclk) begin
    if (!aresetn)
      rddata_vld <= 1'b0;
    else if (buf_xfer)
      rddata_vld <= 1'b1;
    else if (usr_xfer | wdog_exp)  // held beat dropped on timeout
      rddata_vld <= 1'b0;
  end

  always_ff @(posedge aclk) begin
    if (buf_xfer) begin
      rddata      <= beat.data;
      rddata_last <= beat_last;
    end
  end

  assign burst_done = usr_last | to_q;
  assign flush      = to_q;        // discard beats of the dead burst
  assign rd_sts_vld = usr_last | to_q;

  // Count includes the beat taken in this cycle
  assign rd_sts.beat_cnt = usr_xfer ? acc_cnt + 1'b1 : acc_cnt;
  assign rd_sts.timeout  = to_q;
  assign rd_sts.id_err   = id_err_q;
  assign rd_sts.resp_err = resp_err_q;

endmodule

// ==== hw/rd_cmd_issuer.sv ====
// Read command issuer
`timescale 1ns/1ps

module rd_cmd_issuer (
  input  logic                    aclk,
  input  logic                    aresetn,
  // User command port
  input  logic                    cmd_en,
  input  axi_rd_pkg::rd_cmd_t     cmd,
  output logic                    cmd_ack,
  // AR channel
  output axi_rd_pkg::ar_chan_t    ar,
  output logic                    arvalid,
  input  logic                    arready,
  // To burst tracker
  output logic                    burst_start,
  output axi_rd_pkg::burst_info_t burst,
  input  logic                    burst_done
);

  import axi_rd_pkg::*;

  // Byte offset bits inside one data word
  localparam int ALIGN_W = $clog2(DATA_W / 8);

  logic              busy;          // burst open, no new command
  logic [ID_W-1:0]   id_cnt;        // rolling transaction ID
  logic              accept;
  logic [ADDR_W-1:0] addr_aligned;

  assign accept       = cmd_en & ~busy;
  assign addr_aligned = {cmd.addr[ADDR_W-1:ALIGN_W], {ALIGN_W{1'b0}}};

  //**************************************************************************
  // Command handshake and burst ownership
  //**************************************************************************

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      busy        <= 1'b0;
      cmd_ack     <= 1'b0;
      burst_start <= 1'b0;
    end else begin
      cmd_ack     <= accept;  // single pulse, busy blocks a repeat
      burst_start <= accept;
      if (accept)
        busy <= 1'b1;
      else if (burst_done)
        busy <= 1'b0;
    end
  end

  // ID moves on once the burst is closed, normally or by timeout
  always_ff @(posedge aclk) begin
    if (!aresetn)
      id_cnt <= '0;
    else if (burst_done)
      id_cnt <= id_cnt + 1'b1;
  end

  //**************************************************************************
  // Read address channel
  //**************************************************************************

  always_ff @(posedge aclk) begin
    if (!aresetn)
      arvalid <= 1'b0;
    else if (accept)
      arvalid <= 1'b1;
    else if (arready | burst_done)  // burst_done here means abandoned
      arvalid <= 1'b0;
  end

  always_ff @(posedge aclk) begin
    if (accept) begin
      ar.id    <= id_cnt;
      ar.addr  <= addr_aligned;
      ar.len   <= cmd.blen;
      ar.size  <= cmd.size;
      ar.burst <= cmd.wrap ? BURST_WRAP : BURST_INCR;
    end
  end

  // Expectation for the tracker, stable for the whole burst
  assign burst.id  = ar.id;
  assign burst.len = ar.len;

endmodule

// ==== project.f ====
hw/axi_rd_pkg.sv
hw/rd_cmd_issuer.sv
hw/rd_beat_buffer.sv
hw/rd_burst_tracker.sv
hw/axi_rd_master.sv
bench/axi_rd_slave_model.sv
bench/axi_rd_master_tb.sv
